//--- list.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/set_array.sv
verilog/plru_policy.sv
verilog/cache_datapath.sv
verilog/cache_control.sv
verilog/cache_top.sv
tests/cache_checker.sv
tests/tb_cache.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -f list.f -o tb_cache

status=0
out=$(./obj_dir/tb_cache) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx 'Test passed'; then
	exit 0
fi
exit 1

//--- tests/cache_checker.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_checker
	import cache_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  mem_read,
	input  logic  mem_write,
	input  addr_t mem_address,
	input  line_t mem_wdata,
	input  line_t mem_rdata,
	input  logic  mem_resp,
	input  logic  pmem_read,
	input  logic  pmem_write,
	input  addr_t pmem_address,
	input  line_t pmem_wdata,
	input  logic  pmem_resp,
	output int    error_count,
	output int    read_count,
	output int    writeback_count
);

	// shadow of every line the CPU wrote, and which of them memory has not seen yet
	line_t shadow [addr_t];
	bit    written [addr_t];
	logic  seen_request;
	logic  in_flight;
	logic  repeat_access;
	logic  resp_prev;
	logic  have_last;
	addr_t cur_line;
	addr_t last_line;

	function automatic addr_t line_base(input addr_t addr);
		return {addr[31:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
	endfunction

	// backing store contents before any write
	function automatic line_t initial_line(input addr_t base);
		line_t l;
		for (int i = 0; i < `CACHE_LINE_W / 32; i++)
			l[i*32 +: 32] = (base + 32'(i * 4)) * 32'h9E3779B1 ^ 32'h6D2B79F5;
		return l;
	endfunction

	task automatic flag_error(input string what);
		$display("%s", what);
		error_count++;
	endtask

	task automatic check_memory_transfer();
		if (pmem_address != line_base(pmem_address))
			flag_error($sformatf("Error: pmem_address: expected %h, got %h",
				line_base(pmem_address), pmem_address));
		if (pmem_read) begin
			written.delete(pmem_address);
		end else if (!written.exists(pmem_address)) begin
			flag_error($sformatf("write-back of line %h that the CPU has not written",
				pmem_address));
		end else begin
			writeback_count++;
			if (pmem_wdata !== shadow[pmem_address])
				flag_error($sformatf("Error: pmem_wdata at %h: expected %h, got %h",
					pmem_address, shadow[pmem_address], pmem_wdata));
			written.delete(pmem_address);
		end
	endtask

	task automatic check_cpu_response();
		line_t expected;
		if (!in_flight) begin
			flag_error("mem_resp came without a pending request");
		end else if (mem_read) begin
			expected = shadow.exists(cur_line) ? shadow[cur_line] : initial_line(cur_line);
			read_count++;
			if (mem_rdata !== expected)
				flag_error($sformatf("Error: mem_rdata at %h: expected %h, got %h",
					cur_line, expected, mem_rdata));
		end else begin
			shadow[cur_line] = mem_wdata;
			written[cur_line] = 1'b1;
		end
		in_flight = 1'b0;
		last_line = cur_line;
		have_last = 1'b1;
	endtask

	initial begin
		error_count = 0;
		read_count = 0;
		writeback_count = 0;
	end

	////////////////////////////////////////////////////////////
	// sampled mid-cycle, after inputs and outputs have settled
	always @(negedge clk) begin
		if (rst) begin
			seen_request = 1'b0;
			in_flight = 1'b0;
			have_last = 1'b0;
			resp_prev = 1'b0;
		end else begin
			if (mem_read || mem_write)
				seen_request = 1'b1;
			else if (!seen_request && (mem_resp || pmem_read || pmem_write))
				flag_error("cache outputs went high before the first request");
			if (pmem_read && pmem_write)
				flag_error("pmem_read and pmem_write were high together");
			if (mem_resp && resp_prev)
				flag_error("mem_resp stayed high for more than one cycle");
			resp_prev = mem_resp;
			if ((mem_read || mem_write) && !in_flight) begin
				in_flight = 1'b1;
				cur_line = line_base(mem_address);
				repeat_access = have_last && (cur_line == last_line);
			end
			// line just used must still be resident
			if (in_flight && repeat_access && (pmem_read || pmem_write)) begin
				flag_error($sformatf("repeated access to line %h went to memory", cur_line));
				repeat_access = 1'b0;
			end
			if (pmem_resp && (pmem_read || pmem_write))
				check_memory_transfer();
			if (mem_resp)
				check_cpu_response();
		end
	end

endmodule

//--- tests/tb_cache.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_cache
	import cache_pkg::*;
();

	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

	localparam logic [31:0] SEED = 32'h23521018;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_REQUESTS = 400;
	localparam int NUM_TAGS = 12;
	// compare, write-back and fill at 4-cycle memory delay, compare again, idle gap
	localparam int WORST_CYCLES = 20;
	localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_REQUESTS * WORST_CYCLES) * CLK_PERIOD * 2;

	logic  clk;
	logic  rst;
	logic  mem_read;
	logic  mem_write;
	addr_t mem_address;
	line_t mem_wdata;
	line_t mem_rdata;
	logic  mem_resp;
	logic  pmem_read;
	logic  pmem_write;
	addr_t pmem_address;
	line_t pmem_wdata;
	line_t pmem_rdata;
	logic  pmem_resp;
	int    error_count;
	int    read_count;
	int    writeback_count;

	line_t mem_store [addr_t];
	tag_t  tag_pool [NUM_TAGS];

	cache_top dut (.*);

	cache_checker chk (.*);

	function automatic line_t initial_line(input addr_t base);
		line_t l;
		for (int i = 0; i < `CACHE_LINE_W / 32; i++)
			l[i*32 +: 32] = (base + 32'(i * 4)) * 32'h9E3779B1 ^ 32'h6D2B79F5;
		return l;
	endfunction

	function automatic line_t stored_line(input addr_t base);
		if (mem_store.exists(base))
			return mem_store[base];
		else
			return initial_line(base);
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int i = 0; i < `CACHE_LINE_W / 32; i++)
			l[i*32 +: 32] = $urandom;
		return l;
	endfunction

	function automatic addr_t random_address();
		tag_t tag;
		index_t index;
		tag = tag_pool[$urandom_range(0, NUM_TAGS - 1)];
		index = index_t'($urandom);
		return {tag, index, offset_t'($urandom)};
	endfunction

	task automatic print_summary();
		$display("reads checked %0d, write-backs checked %0d, errors %0d",
			read_count, writeback_count, error_count);
	endtask

	// holds the request until mem_resp, then drops it after the edge
	task automatic cpu_access(input logic is_write, input addr_t addr, input line_t data);
		mem_read = ~is_write;
		mem_write = is_write;
		mem_address = addr;
		mem_wdata = data;
		@(negedge clk);
		while (!mem_resp)
			@(negedge clk);
		@(posedge clk);
		#1;
		mem_read = 1'b0;
		mem_write = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// line memory behind the cache
	initial begin : memory_model
		int    delay;
		addr_t req_addr;
		logic  req_write;
		line_t req_data;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		forever begin
			@(negedge clk);
			if (!rst && (pmem_read || pmem_write)) begin
				req_addr = pmem_address;
				req_write = pmem_write;
				req_data = pmem_wdata;
				delay = $urandom_range(1, 4);
				repeat (delay) @(posedge clk);
				#1;
				if (req_write)
					mem_store[req_addr] = req_data;
				else
					pmem_rdata = stored_line(req_addr);
				pmem_resp = 1'b1;
				@(posedge clk);
				#1;
				pmem_resp = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// random CPU traffic
	initial begin : stimulus
		addr_t addr;
		addr_t prev_addr;
		logic  is_write;
		void'($urandom(SEED));
		rst = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		// low bits keep the tags distinct
		for (int i = 0; i < NUM_TAGS; i++)
			tag_pool[i] = tag_t'(($urandom & 32'hFFFFF0) | i);
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		prev_addr = random_address();
		for (int n = 0; n < NUM_REQUESTS; n++) begin
			if (n > 0 && $urandom_range(0, 3) == 0)
				addr = {prev_addr[31:`CACHE_OFFSET_W], offset_t'($urandom)};
			else
				addr = random_address();
			is_write = ($urandom_range(0, 1) == 1);
			cpu_access(is_write, addr, random_line());
			prev_addr = addr;
			if ($urandom_range(0, 3) == 0) begin
				repeat ($urandom_range(1, 2)) @(posedge clk);
				#1;
			end
		end
		repeat (5) @(posedge clk);
		print_summary();
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout: requests did not finish within %0d ns", TIMEOUT_NS);
		print_summary();
		$display("Test failed");
		$finish;
	end

endmodule

//--- verilog/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address split into tag, index and byte offset
`define CACHE_OFFSET_W 5
`define CACHE_INDEX_W  3
`define CACHE_TAG_W    (32 - `CACHE_INDEX_W - `CACHE_OFFSET_W)

// associativity
`define CACHE_WAYS     8
`define CACHE_WAY_W    3

// one line is 2**offset bytes
`define CACHE_LINE_W   (8 << `CACHE_OFFSET_W)

// tree pseudo-LRU, one bit per inner node
`define CACHE_LRU_W    (`CACHE_WAYS - 1)

`endif

//--- verilog/cache_control.sv
`timescale 1ns/1ps

module cache_control
	import cache_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic mem_read,
	input  logic mem_write,
	input  logic pmem_resp,
	input  logic hit,
	input  logic victim_dirty,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output logic load_cmar,
	output logic load_cmdr,
	output logic load_tag,
	output logic load_valid,
	output logic load_dirty,
	output logic dirty_in,
	output logic fill_sel,
	output logic load_lru
);

	cache_state_t state;
	cache_state_t next_state;

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		mem_resp   = 1'b0;
		pmem_read  = 1'b0;
		pmem_write = 1'b0;
		load_cmar  = 1'b0;
		load_cmdr  = 1'b0;
		load_tag   = 1'b0;
		load_valid = 1'b0;
		load_dirty = 1'b0;
		dirty_in   = 1'b0;
		fill_sel   = 1'b0;
		load_lru   = 1'b0;
		case (state)
			IDLE: begin
				if (mem_read || mem_write)
					next_state = COMPARE;
			end
			COMPARE: begin
				if (!(mem_read || mem_write)) begin
					next_state = IDLE;
				end else if (hit) begin
					mem_resp   = 1'b1;
					load_lru   = 1'b1;
					load_dirty = mem_write;
					dirty_in   = mem_write;
					next_state = IDLE;
				end else if (victim_dirty) begin
					// victim address and line go out first
					load_cmar  = 1'b1;
					load_cmdr  = 1'b1;
					next_state = WRITEBACK;
				end else if (mem_read) begin
					load_cmar  = 1'b1;
					next_state = FILL;
				end else begin
					// full-line write miss allocates without a fill
					load_tag   = 1'b1;
					load_valid = 1'b1;
					load_dirty = 1'b1;
					dirty_in   = 1'b1;
					load_lru   = 1'b1;
					mem_resp   = 1'b1;
					next_state = IDLE;
				end
			end
			WRITEBACK: begin
				pmem_write = 1'b1;
				if (pmem_resp) begin
					load_dirty = 1'b1;
					if (mem_read) begin
						load_cmar  = 1'b1;
						next_state = FILL;
					end else begin
						next_state = COMPARE;
					end
				end
			end
			FILL: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					load_tag   = 1'b1;
					load_valid = 1'b1;
					fill_sel   = 1'b1;
					next_state = COMPARE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	// one memory transaction at a time
	assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write));

	// CPU response is a single-cycle pulse
	assert property (@(posedge clk) disable iff (rst) mem_resp |=> !mem_resp);

endmodule

//--- verilog/cache_datapath.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_datapath
	import cache_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  addr_t mem_address,
	input  line_t mem_wdata,
	input  line_t pmem_rdata,
	input  logic  load_cmar,
	input  logic  load_cmdr,
	input  logic  load_tag,
	input  logic  load_valid,
	input  logic  load_dirty,
	input  logic  dirty_in,
	input  logic  fill_sel,
	input  logic  load_lru,
	output line_t mem_rdata,
	output addr_t pmem_address,
	output line_t pmem_wdata,
	output logic  hit,
	output logic  victim_dirty
);

	localparam int SETS = 1 << `CACHE_INDEX_W;

	index_t    index;
	tag_t      tag;
	line_t     line_in;
	line_t     line_out [`CACHE_WAYS];
	tag_t      tag_out [`CACHE_WAYS];
	way_vec_t  valid_q [SETS];
	way_vec_t  dirty_q [SETS];
	way_vec_t  hit_vec;
	way_vec_t  target_vec;
	way_t      hit_way;
	way_t      victim_way;
	way_t      target_way;
	lru_bits_t lru_cur;
	lru_bits_t lru_next;
	logic      line_load;
	logic      wb_sel;
	addr_t     cmar_in;

	assign index = mem_address[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign tag   = mem_address[(`CACHE_OFFSET_W + `CACHE_INDEX_W) +: `CACHE_TAG_W];

	// fill takes the memory line, CPU writes take the whole wdata line
	assign line_in = fill_sel ? pmem_rdata : mem_wdata;
	// a line is written on fill/allocate and on every dirtying write
	assign line_load = load_valid | (load_dirty & dirty_in);

	////////////////////////////////////////////////////////////
	// per-way tag and line storage
	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
		set_array #(.payload_t(line_t), .SETS(SETS)) u_line (
			.clk(clk), .rst(rst), .load(line_load & target_vec[w]),
			.rindex(index), .windex(index),
			.datain(line_in), .dataout(line_out[w])
		);
		set_array #(.payload_t(tag_t), .SETS(SETS)) u_tag (
			.clk(clk), .rst(rst), .load(load_tag & target_vec[w]),
			.rindex(index), .windex(index),
			.datain(tag), .dataout(tag_out[w])
		);
		assign hit_vec[w] = valid_q[index][w] && (tag_out[w] == tag);
	end

	set_array #(.payload_t(lru_bits_t), .SETS(SETS)) u_lru (
		.clk(clk), .rst(rst), .load(load_lru),
		.rindex(index), .windex(index),
		.datain(lru_next), .dataout(lru_cur)
	);

	plru_policy u_plru (
		.cur_bits(lru_cur), .touched_way(target_way),
		.next_bits(lru_next), .victim_way(victim_way)
	);

	////////////////////////////////////////////////////////////
	// hit check and target way
	always_comb begin
		hit_way = '0;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (hit_vec[w])
				hit_way = way_t'(w);
		end
	end

	assign hit        = |hit_vec;
	assign mem_rdata  = hit ? line_out[hit_way] : '0;
	assign target_way = hit ? hit_way : victim_way;
	assign target_vec = way_vec_t'(1) << target_way;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else begin
			if (load_valid)
				valid_q[index] <= valid_q[index] | target_vec;
			if (load_dirty) begin
				if (dirty_in)
					dirty_q[index] <= dirty_q[index] | target_vec;
				else
					dirty_q[index] <= dirty_q[index] & ~target_vec;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// write-back registers toward memory
	assign victim_dirty = dirty_q[index][victim_way];
	// dirtiness as it stands after this cycle's dirty update
	assign wb_sel = victim_dirty & ~(load_dirty & ~dirty_in);
	assign cmar_in = wb_sel ? {tag_out[victim_way], index, {`CACHE_OFFSET_W{1'b0}}}
	                        : {tag, index, {`CACHE_OFFSET_W{1'b0}}};

	always_ff @(posedge clk) begin
		if (load_cmar)
			pmem_address <= cmar_in;
		if (load_cmdr)
			pmem_wdata <= line_out[victim_way];
	end

endmodule

//--- verilog/cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

	typedef logic [31:0] addr_t;

	typedef logic [`CACHE_TAG_W-1:0] tag_t;

	typedef logic [`CACHE_INDEX_W-1:0] index_t;

	typedef logic [`CACHE_LINE_W-1:0] line_t;

	typedef logic [`CACHE_WAY_W-1:0] way_t;

	// per-way flags or a one-hot way select
	typedef logic [`CACHE_WAYS-1:0] way_vec_t;

	typedef logic [`CACHE_LRU_W-1:0] lru_bits_t;

	typedef enum logic [1:0] {
		IDLE,
		COMPARE,
		WRITEBACK,
		FILL
	} cache_state_t;

endpackage

//--- verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top
	import cache_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	// CPU side
	input  logic  mem_read,
	input  logic  mem_write,
	input  addr_t mem_address,
	input  line_t mem_wdata,
	output line_t mem_rdata,
	output logic  mem_resp,
	// memory side
	output logic  pmem_read,
	output logic  pmem_write,
	output addr_t pmem_address,
	output line_t pmem_wdata,
	input  line_t pmem_rdata,
	input  logic  pmem_resp
);

	logic load_cmar;
	logic load_cmdr;
	logic load_tag;
	logic load_valid;
	logic load_dirty;
	logic dirty_in;
	logic fill_sel;
	logic load_lru;
	logic hit;
	logic victim_dirty;

	cache_control u_control (
		.clk(clk), .rst(rst),
		.mem_read(mem_read), .mem_write(mem_write), .pmem_resp(pmem_resp),
		.hit(hit), .victim_dirty(victim_dirty),
		.mem_resp(mem_resp), .pmem_read(pmem_read), .pmem_write(pmem_write),
		.load_cmar(load_cmar), .load_cmdr(load_cmdr), .load_tag(load_tag),
		.load_valid(load_valid), .load_dirty(load_dirty), .dirty_in(dirty_in),
		.fill_sel(fill_sel), .load_lru(load_lru)
	);

	cache_datapath u_datapath (
		.clk(clk), .rst(rst),
		.mem_address(mem_address), .mem_wdata(mem_wdata), .pmem_rdata(pmem_rdata),
		.load_cmar(load_cmar), .load_cmdr(load_cmdr), .load_tag(load_tag),
		.load_valid(load_valid), .load_dirty(load_dirty), .dirty_in(dirty_in),
		.fill_sel(fill_sel), .load_lru(load_lru),
		.mem_rdata(mem_rdata), .pmem_address(pmem_address), .pmem_wdata(pmem_wdata),
		.hit(hit), .victim_dirty(victim_dirty)
	);

endmodule

//--- verilog/plru_policy.sv
`timescale 1ns/1ps

module plru_policy
	import cache_pkg::*;
(
	input  lru_bits_t cur_bits,
	input  way_t      touched_way,
	output lru_bits_t next_bits,
	output way_t      victim_way
);

	// node 0 is the root, 1..2 the middle level and 3..6 the level above the leaves
	// a node bit of 0 points the victim at the lower half

	logic [2:0] v_mid_node;
	logic [2:0] v_low_node;
	logic [2:0] t_mid_node;
	logic [2:0] t_low_node;

	always_comb begin
		// walk down to the victim leaf
		victim_way[2] = cur_bits[0];
		v_mid_node = 3'd1 + {2'b00, victim_way[2]};
		victim_way[1] = cur_bits[v_mid_node];
		v_low_node = 3'd3 + {1'b0, victim_way[2:1]};
		victim_way[0] = cur_bits[v_low_node];

		// flip the touched path so every node points away from it
		t_mid_node = 3'd1 + {2'b00, touched_way[2]};
		t_low_node = 3'd3 + {1'b0, touched_way[2:1]};
		next_bits = cur_bits;
		next_bits[0] = ~touched_way[2];
		next_bits[t_mid_node] = ~touched_way[1];
		next_bits[t_low_node] = ~touched_way[0];

		// tree already steers away, so the walk must not land on it
		if (next_bits == cur_bits) begin
			assert (victim_way != touched_way)
			else $error("plru victim %0d equals touched way", victim_way);
		end
	end

endmodule

//--- verilog/set_array.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module set_array #(
	parameter type payload_t = logic,
	parameter int  SETS      = 1 << `CACHE_INDEX_W,
	localparam int IDX_W     = (SETS > 1) ? $clog2(SETS) : 1
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             load,
	input  logic [IDX_W-1:0] rindex,
	input  logic [IDX_W-1:0] windex,
	input  payload_t         datain,
	output payload_t         dataout
);

	payload_t data [SETS];

	// write lands on the next edge
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < SETS; s++) begin
				data[s] <= '0;
			end
		end else if (load) begin
			data[windex] <= datain;
		end
	end

	// read is combinational
	assign dataout = data[rindex];

endmodule
